//--- common/aes_pkg.sv
////////////////////////////////////////
// AES arithmetic package
// Byte, word and key types, S-box lookup
// and GF(2^8) helpers for key expansion
////////////////////////////////////////

package aes_pkg;

  // Key register geometry
  localparam int NumKeyWords = 8;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef logic [7:0]  aes_byte_t;
  typedef logic [31:0] aes_word_t;
  // Word 0 sits in the lowest 32 bits
  typedef aes_word_t [NumKeyWords-1:0] aes_key_t;
  typedef logic [3:0]  round_t;
  typedef logic [7:0]  rcon_t;

  ////////////////////////////////////////
  // Forward S-box table
  ////////////////////////////////////////

  // One row per upper nibble, leftmost byte is column 0
  localparam logic [127:0] SboxRows [16] = '{
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  ////////////////////////////////////////
  // Functions
  ////////////////////////////////////////

  // SubBytes on a single byte
  function automatic aes_byte_t aes_sbox(aes_byte_t in);
    logic [127:0] row;
    int           col;
    row = SboxRows[in[7:4]];
    // Column 0 is the most significant byte of the row
    col = 15 - int'(in[3:0]);
    return row[8*col +: 8];
  endfunction

  // Multiply by x in GF(2^8), reduction polynomial 0x11b
  function automatic aes_byte_t aes_mul2(aes_byte_t in);
    aes_byte_t out;
    out = {in[6:0], 1'b0};
    if (in[7]) begin
      out = out ^ 8'h1b;
    end
    return out;
  endfunction

  // Divide by x, exact inverse of aes_mul2
  function automatic aes_byte_t aes_div2(aes_byte_t in);
    aes_byte_t out;
    // Odd input means the reduction was applied, so bit 7 was set
    if (in[0]) begin
      out = {1'b1, in[7:1] ^ 7'h0d};
    end else begin
      out = {1'b0, in[7:1]};
    end
    return out;
  endfunction

  // RotWord, byte 1 moves into byte 0
  function automatic aes_word_t aes_rot_byte(aes_word_t in);
    return {in[7:0], in[31:8]};
  endfunction

endpackage

//--- common/aes_key_pkg.sv
////////////////////////////////////////
// AES key schedule control package
// Mode encodings, control word, Rcon starts
////////////////////////////////////////

package aes_key_pkg;

  ////////////////////////////////////////
  // Mode encodings
  ////////////////////////////////////////

  // Direction through the schedule
  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  // Supported key lengths
  typedef enum logic {
    AES_128 = 1'b0,
    AES_256 = 1'b1
  } key_len_e;

  ////////////////////////////////////////
  // Control word to the datapath
  ////////////////////////////////////////

  typedef struct packed {
    ciph_op_e op;
    key_len_e key_len;
    // Rotate the selected word before SubWord
    logic     use_rot_word;
    // Add Rcon and advance the Rcon register
    logic     use_rcon;
    // AES-256 round 0, key passes through
    logic     hold;
  } key_ctrl_t;

  // Rcon start values on a clear pulse
  localparam aes_pkg::rcon_t RconFwdInit    = 8'h01;
  localparam aes_pkg::rcon_t RconInv128Init = 8'h36;
  localparam aes_pkg::rcon_t RconInv256Init = 8'h40;

endpackage

//--- key_expand/aes_key_ctrl.sv
////////////////////////////////////////
// AES key expansion control
// Decodes round and mode into the datapath
// control word and owns the Rcon register
////////////////////////////////////////

module aes_key_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  aes_key_pkg::ciph_op_e  op_i,
  input  aes_key_pkg::key_len_e  key_len_i,
  input  aes_pkg::round_t        round_i,
  input  logic                   en_i,
  input  logic                   clear_i,
  output aes_key_pkg::key_ctrl_t ctrl_o,
  output aes_pkg::rcon_t         rcon_o
);
  import aes_pkg::*;
  import aes_key_pkg::*;

  logic  odd_round;
  logic  first_round;
  rcon_t rcon_d;
  rcon_t rcon_q;

  ////////////////////////////////////////
  // Round decode
  ////////////////////////////////////////

  assign odd_round   = round_i[0];
  assign first_round = (round_i == '0);

  always_comb begin : decode
    ctrl_o.op      = op_i;
    ctrl_o.key_len = key_len_i;
    if (key_len_i == AES_128) begin
      // Every AES-128 round is a full round
      ctrl_o.use_rot_word = 1'b1;
      ctrl_o.use_rcon     = 1'b1;
      ctrl_o.hold         = 1'b0;
    end else begin
      // AES-256 alternates, even rounds are SubWord only
      ctrl_o.use_rot_word = odd_round;
      ctrl_o.use_rcon     = odd_round;
      // Round 0 has no key computation
      ctrl_o.hold         = first_round;
    end
  end

  ////////////////////////////////////////
  // Rcon register
  ////////////////////////////////////////

  always_comb begin : rcon_next
    rcon_d = rcon_q;
    if (clear_i) begin
      // Start of a new schedule
      if (op_i == CIPH_FWD) begin
        rcon_d = RconFwdInit;
      end else if (key_len_i == AES_128) begin
        rcon_d = RconInv128Init;
      end else begin
        rcon_d = RconInv256Init;
      end
    end else if (en_i && ctrl_o.use_rcon) begin
      // Step only in rounds that consumed Rcon
      rcon_d = (op_i == CIPH_FWD) ? aes_mul2(rcon_q) : aes_div2(rcon_q);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : rcon_reg
    if (!rst_ni) begin
      rcon_q <= '0;
    end else begin
      rcon_q <= rcon_d;
    end
  end

  assign rcon_o = rcon_q;

endmodule

//--- key_expand/aes_key_word_sel.sv
////////////////////////////////////////
// AES key word select
// Picks the word for SubWord, then RotWord
////////////////////////////////////////

module aes_key_word_sel (
  input  aes_key_pkg::key_ctrl_t ctrl_i,
  input  aes_pkg::aes_key_t      key_i,
  output aes_pkg::aes_word_t     word_o
);
  import aes_pkg::*;
  import aes_key_pkg::*;

  aes_word_t sel_word;
  aes_word_t inv_128_word;

  // Previous word 3 of an AES-128 key, rebuilt from the new key
  assign inv_128_word = key_i[3] ^ key_i[2];

  always_comb begin : sel_mux
    if (ctrl_i.key_len == AES_128) begin
      if (ctrl_i.op == CIPH_FWD) begin
        sel_word = key_i[3];
      end else begin
        sel_word = inv_128_word;
      end
    end else begin
      // AES-256 forward uses the newest word, inverse the last old word
      if (ctrl_i.op == CIPH_FWD) begin
        sel_word = key_i[7];
      end else begin
        sel_word = key_i[3];
      end
    end
  end

  // RotWord only where the round calls for it
  assign word_o = ctrl_i.use_rot_word ? aes_rot_byte(sel_word) : sel_word;

endmodule

//--- key_expand/aes_sub_word.sv
////////////////////////////////////////
// AES SubWord with Rcon addition
// Four table S-boxes, Rcon into byte 0
////////////////////////////////////////

module aes_sub_word (
  input  aes_key_pkg::key_ctrl_t ctrl_i,
  input  aes_pkg::rcon_t         rcon_i,
  input  aes_pkg::aes_word_t     word_i,
  output aes_pkg::aes_word_t     word_o
);
  import aes_pkg::*;

  aes_word_t sub_word;
  aes_byte_t rcon_byte;

  ////////////////////////////////////////
  // Byte substitution
  ////////////////////////////////////////

  // Each byte goes through its own lookup
  always_comb begin : sbox_bytes
    for (int i = 0; i < 4; i++) begin
      sub_word[8*i +: 8] = aes_sbox(word_i[8*i +: 8]);
    end
  end

  ////////////////////////////////////////
  // Rcon addition
  ////////////////////////////////////////

  // Zero in rounds without Rcon
  assign rcon_byte = ctrl_i.use_rcon ? rcon_i : '0;

  // Rcon only touches the lowest byte
  assign word_o = {sub_word[31:8], sub_word[7:0] ^ rcon_byte};

endmodule

//--- key_expand/aes_key_mix.sv
////////////////////////////////////////
// AES key mix
// XOR chains forming the next or previous
// round key from the irregular word
////////////////////////////////////////

module aes_key_mix (
  input  aes_key_pkg::key_ctrl_t ctrl_i,
  input  aes_pkg::aes_key_t      key_i,
  input  aes_pkg::aes_word_t     irregular_i,
  output aes_pkg::aes_key_t      key_o
);
  import aes_pkg::*;
  import aes_key_pkg::*;

  aes_key_t key_d;

  always_comb begin : mix
    // Hold round keeps the whole register
    key_d = key_i;

    if (!ctrl_i.hold) begin
      if (ctrl_i.key_len == AES_128) begin

        ////////////////////////////////////////
        // AES-128
        ////////////////////////////////////////

        // Upper half unused, mirror the lower half
        key_d[7:4] = key_i[3:0];
        // First word always takes the irregular part
        key_d[0]   = irregular_i ^ key_i[0];

        if (ctrl_i.op == CIPH_FWD) begin
          // Chain through the freshly made words
          for (int i = 1; i < 4; i++) begin
            key_d[i] = key_d[i-1] ^ key_i[i];
          end
        end else begin
          // Undo the chain from neighbouring new words
          for (int i = 1; i < 4; i++) begin
            key_d[i] = key_i[i-1] ^ key_i[i];
          end
        end

      end else begin

        ////////////////////////////////////////
        // AES-256
        ////////////////////////////////////////

        if (ctrl_i.op == CIPH_FWD) begin
          // Old upper half becomes the lower half
          key_d[3:0] = key_i[7:4];
          // New upper half from the old lower half
          key_d[4]   = irregular_i ^ key_i[0];
          for (int i = 1; i < 4; i++) begin
            key_d[i+4] = key_d[i+3] ^ key_i[i];
          end
        end else begin
          // Old lower half becomes the upper half
          key_d[7:4] = key_i[3:0];
          // Recover the previous lower half
          key_d[0]   = irregular_i ^ key_i[4];
          for (int i = 0; i < 3; i++) begin
            key_d[i+1] = key_i[4+i] ^ key_i[5+i];
          end
        end

      end
    end
  end

  assign key_o = key_d;

endmodule

//--- key_expand/aes_key_expand.sv
////////////////////////////////////////
// AES key expansion top
// One round key step per cycle, forward
// or inverse, AES-128 and AES-256
////////////////////////////////////////

module aes_key_expand (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  aes_key_pkg::ciph_op_e op_i,
  input  aes_key_pkg::key_len_e key_len_i,
  input  aes_pkg::round_t       round_i,
  input  logic                  en_i,
  input  logic                  clear_i,
  input  aes_pkg::aes_key_t     key_i,
  output aes_pkg::aes_key_t     key_o
);
  import aes_pkg::*;
  import aes_key_pkg::*;

  key_ctrl_t ctrl;
  rcon_t     rcon;
  aes_word_t sel_word;
  aes_word_t irregular;

  // Control decode and Rcon state
  aes_key_ctrl u_ctrl (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .op_i      (op_i),
    .key_len_i (key_len_i),
    .round_i   (round_i),
    .en_i      (en_i),
    .clear_i   (clear_i),
    .ctrl_o    (ctrl),
    .rcon_o    (rcon)
  );

  // Source word and RotWord
  aes_key_word_sel u_word_sel (
    .ctrl_i (ctrl),
    .key_i  (key_i),
    .word_o (sel_word)
  );

  // SubWord plus Rcon
  aes_sub_word u_sub_word (
    .ctrl_i (ctrl),
    .rcon_i (rcon),
    .word_i (sel_word),
    .word_o (irregular)
  );

  // XOR chains to the output key
  aes_key_mix u_key_mix (
    .ctrl_i      (ctrl),
    .key_i       (key_i),
    .irregular_i (irregular),
    .key_o       (key_o)
  );

endmodule

//--- verif/tb_key_ref.svh
////////////////////////////////////////
// Key schedule reference model
// One forward and one inverse step after
// the FIPS-197 expansion, S-box from GF math
////////////////////////////////////////

`ifndef TB_KEY_REF_SVH
`define TB_KEY_REF_SVH

// Rcon by FIPS round index, entry 0 unused
localparam logic [7:0] RefRcon [11] = '{8'h00, 8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
                                         8'h20, 8'h40, 8'h80, 8'h1b, 8'h36};

// Shift and add product in GF(2^8)
function automatic logic [7:0] gf_mul(logic [7:0] a, logic [7:0] b);
  logic [7:0] p;
  logic [7:0] x;
  p = 8'h00;
  x = a;
  for (int i = 0; i < 8; i++) begin
    if (b[i]) begin
      p = p ^ x;
    end
    if (x[7]) begin
      x = {x[6:0], 1'b0} ^ 8'h1b;
    end else begin
      x = {x[6:0], 1'b0};
    end
  end
  return p;
endfunction

// Multiplicative inverse by search, then the affine map
function automatic logic [7:0] sbox_byte(logic [7:0] a);
  logic [7:0] inv;
  inv = 8'h00;
  for (int y = 1; y < 256; y++) begin
    if (gf_mul(a, 8'(y)) == 8'h01) begin
      inv = 8'(y);
    end
  end
  return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]} ^
         {inv[3:0], inv[7:4]} ^ 8'h63;
endfunction

// FIPS byte a0 lives in bits 7:0
function automatic aes_word_t sub_word_bytes(aes_word_t w);
  return {sbox_byte(w[31:24]), sbox_byte(w[23:16]), sbox_byte(w[15:8]), sbox_byte(w[7:0])};
endfunction

// [a0 a1 a2 a3] becomes [a1 a2 a3 a0]
function automatic aes_word_t rot_word_bytes(aes_word_t w);
  return {w[7:0], w[31:24], w[23:16], w[15:8]};
endfunction

// Transformed temp word of the expansion
function automatic aes_word_t core_word(aes_word_t w, logic rot, logic [7:0] rc);
  aes_word_t v;
  v = rot ? rot_word_bytes(w) : w;
  return sub_word_bytes(v) ^ {24'h000000, rc};
endfunction

// Next window of the schedule, step is the FIPS round
function automatic aes_key_t ref_fwd_step(key_len_e len, aes_key_t k, int step);
  aes_key_t n;
  logic     odd;
  n   = k;
  odd = step[0];
  if (len == AES_128) begin
    n[0] = k[0] ^ core_word(k[3], 1'b1, RefRcon[step]);
    for (int t = 1; t < 4; t++) begin
      n[t] = n[t-1] ^ k[t];
    end
    n[7:4] = k[3:0];
  end else if (step != 0) begin
    // Window slides by four words
    n[3:0] = k[7:4];
    n[4]   = k[0] ^ core_word(k[7], odd, odd ? RefRcon[(step + 1) / 2] : 8'h00);
    for (int t = 1; t < 4; t++) begin
      n[4+t] = n[3+t] ^ k[t];
    end
  end
  return n;
endfunction

// Undoes ref_fwd_step for the same round
function automatic aes_key_t ref_inv_step(key_len_e len, aes_key_t k, int step);
  aes_key_t p;
  logic     odd;
  p   = k;
  odd = step[0];
  if (len == AES_128) begin
    p[3]   = k[3] ^ k[2];
    p[2]   = k[2] ^ k[1];
    p[1]   = k[1] ^ k[0];
    p[0]   = k[0] ^ core_word(p[3], 1'b1, RefRcon[step]);
    p[7:4] = k[3:0];
  end else if (step != 0) begin
    p[7:4] = k[3:0];
    p[0]   = k[4] ^ core_word(k[3], odd, odd ? RefRcon[(step + 1) / 2] : 8'h00);
    for (int t = 1; t < 4; t++) begin
      p[t] = k[4+t] ^ k[3+t];
    end
  end
  return p;
endfunction

`endif

//--- verif/tb_aes_key_expand.sv
////////////////////////////////////////
// AES key expansion testbench
// Directed forward, inverse, freeze and
// random round trip schedules
////////////////////////////////////////

module tb_aes_key_expand;
  import aes_pkg::*;
  import aes_key_pkg::*;

  // Full run takes about 650 cycles and the limit is about three times that
  localparam int          MaxCycles = 2000;
  localparam logic [31:0] Seed      = 32'h1c1fc3fb;
  localparam int          NumRandom = 10;

  // FIPS-197 A.1 cipher key and round 10 key as big endian words
  localparam logic [31:0] Key128 [4]  = '{32'h2b7e1516, 32'h28aed2a6, 32'habf71588,
                                          32'h09cf4f3c};
  localparam logic [31:0] Last128 [4] = '{32'hd014f9a8, 32'hc9ee2589, 32'he13f0cc8,
                                          32'hb6630ca6};
  // FIPS-197 C.3 cipher key and words 56 to 59
  localparam logic [31:0] Key256 [8]  = '{32'h00010203, 32'h04050607, 32'h08090a0b,
                                          32'h0c0d0e0f, 32'h10111213, 32'h14151617,
                                          32'h18191a1b, 32'h1c1d1e1f};
  localparam logic [31:0] Last256 [4] = '{32'h24fc79cc, 32'hbf0979e9, 32'h371ac23c,
                                          32'h6d68de36};

  logic     clk_i;
  logic     rst_ni;
  ciph_op_e op_i;
  key_len_e key_len_i;
  round_t   round_i;
  logic     en_i;
  logic     clear_i;
  aes_key_t key_i;
  aes_key_t key_o;

  int cycles = 0;
  int checks = 0;
  int errors = 0;

  // Reference schedule of the last forward run with the cipher key at index 0
  aes_key_t sched [15];
  aes_key_t fwd128_last;

  `include "tb_key_ref.svh"

  aes_key_expand dut (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .op_i      (op_i),
    .key_len_i (key_len_i),
    .round_i   (round_i),
    .en_i      (en_i),
    .clear_i   (clear_i),
    .key_i     (key_i),
    .key_o     (key_o)
  );

  always #50 clk_i = ~clk_i;

  // Watchdog
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("Timeout after %0d cycles, the schedules did not finish", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Big endian FIPS word to port byte order
  function automatic aes_word_t from_fips(logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  task automatic check_key(input string name, input aes_key_t got, input aes_key_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input aes_word_t got, input aes_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Clear pulse loads the Rcon start value
  task automatic start_schedule(input ciph_op_e op, input key_len_e len);
    @(posedge clk_i);
    op_i      <= op;
    key_len_i <= len;
    en_i      <= 1'b0;
    clear_i   <= 1'b1;
    @(posedge clk_i);
    clear_i   <= 1'b0;
  endtask

  // One cycle with a key applied and the output sampled mid cycle
  task automatic apply_step(input aes_key_t key, input int round, input logic en,
                            output aes_key_t result);
    @(posedge clk_i);
    key_i   <= key;
    round_i <= round_t'(round);
    en_i    <= en;
    @(negedge clk_i);
    result = key_o;
  endtask

  task automatic run_forward(input key_len_e len, input aes_key_t key, input string tag,
                             output aes_key_t last);
    aes_key_t cur;
    aes_key_t got;
    aes_key_t exp;
    int       num;
    num      = (len == AES_128) ? 10 : 13;
    cur      = key;
    exp      = key;
    sched[0] = key;
    start_schedule(CIPH_FWD, len);
    // AES-256 starts with the pass-through round 0
    for (int r = (len == AES_128) ? 1 : 0; r <= num; r++) begin
      apply_step(cur, r, 1'b1, got);
      exp = ref_fwd_step(len, exp, r);
      check_key($sformatf("key_o %s fwd round %0d", tag, r), got, exp);
      cur      = got;
      sched[r] = exp;
    end
    last = cur;
  endtask

  task automatic run_inverse(input key_len_e len, input aes_key_t key, input string tag);
    aes_key_t cur;
    aes_key_t got;
    cur = key;
    start_schedule(CIPH_INV, len);
    for (int r = (len == AES_128) ? 10 : 13; r >= 1; r--) begin
      apply_step(cur, r, 1'b1, got);
      check_key($sformatf("key_o %s inv round %0d", tag, r), got, ref_inv_step(len, cur, r));
      // Must land on the forward key before round r
      if (len == AES_128) begin
        for (int w = 0; w < 4; w++) begin
          check_word($sformatf("key_o[%0d] %s back to %0d", w, tag, r - 1), got[w],
                     sched[r-1][w]);
        end
      end else begin
        check_key($sformatf("key_o %s back to %0d", tag, r - 1), got, sched[r-1]);
      end
      cur = got;
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic fwd_128_schedule();
    aes_key_t key;
    for (int i = 0; i < 4; i++) begin
      key[i]   = from_fips(Key128[i]);
      key[i+4] = from_fips(Key128[i]);
    end
    run_forward(AES_128, key, "fips128", fwd128_last);
    for (int i = 0; i < 4; i++) begin
      check_word($sformatf("key_o[%0d] fips128 round 10", i), fwd128_last[i],
                 from_fips(Last128[i]));
    end
  endtask

  task automatic fwd_256_schedule(output aes_key_t last);
    aes_key_t key;
    for (int i = 0; i < 8; i++) begin
      key[i] = from_fips(Key256[i]);
    end
    run_forward(AES_256, key, "fips256", last);
    for (int i = 0; i < 4; i++) begin
      check_word($sformatf("key_o[%0d] fips256 round 13", i + 4), last[i+4],
                 from_fips(Last256[i]));
    end
  endtask

  // Round 5 is held with en_i low for four cycles
  task automatic rcon_freeze();
    aes_key_t cur;
    aes_key_t got;
    for (int i = 0; i < 4; i++) begin
      cur[i]   = from_fips(Key128[i]);
      cur[i+4] = from_fips(Key128[i]);
    end
    start_schedule(CIPH_FWD, AES_128);
    for (int r = 1; r <= 10; r++) begin
      if (r == 5) begin
        repeat (4) begin
          apply_step(cur, r, 1'b0, got);
          check_key("key_o frozen round 5", got, ref_fwd_step(AES_128, cur, r));
        end
      end
      apply_step(cur, r, 1'b1, got);
      check_key($sformatf("key_o freeze run round %0d", r), got, ref_fwd_step(AES_128, cur, r));
      cur = got;
    end
    for (int i = 0; i < 4; i++) begin
      check_word($sformatf("key_o[%0d] after freeze", i), cur[i], from_fips(Last128[i]));
    end
  endtask

  task automatic random_round_trip();
    aes_key_t key;
    aes_key_t last;
    for (int n = 0; n < NumRandom; n++) begin
      for (int w = 0; w < NumKeyWords; w++) begin
        key[w] = $urandom();
      end
      run_forward(AES_128, key, "rnd128", last);
      run_inverse(AES_128, last, "rnd128");
      run_forward(AES_256, key, "rnd256", last);
      run_inverse(AES_256, last, "rnd256");
    end
  endtask

  initial begin
    aes_key_t fwd256_last;
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    op_i      = CIPH_FWD;
    key_len_i = AES_128;
    round_i   = '0;
    en_i      = 1'b0;
    clear_i   = 1'b0;
    key_i     = '0;
    void'($urandom(Seed));
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Inverse runs check against the forward run just before them
    fwd_128_schedule();
    run_inverse(AES_128, fwd128_last, "fips128");
    fwd_256_schedule(fwd256_last);
    run_inverse(AES_256, fwd256_last, "fips256");
    rcon_freeze();
    random_round_trip();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+verif
common/aes_pkg.sv
common/aes_key_pkg.sv
key_expand/aes_key_ctrl.sv
key_expand/aes_key_word_sel.sv
key_expand/aes_sub_word.sv
key_expand/aes_key_mix.sv
key_expand/aes_key_expand.sv
verif/tb_aes_key_expand.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the AES key expansion testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_aes_key_expand \
  -o tb_aes_key_expand > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

# A crash without a closing message counts as a failure
./obj_dir/tb_aes_key_expand > sim.log 2>&1 || echo "TEST FAILED" >> sim.log
cat sim.log

grep -q "TEST FAILED" sim.log && { echo "Simulation failed"; exit 1; }
echo "Simulation passed"
